// ==== calc_pkg.sv ====
package calc_pkg;

    // keypad timing, kept short so simulation stays fast
    localparam int SCAN_CYCLES     = 8;    // clocks each column is driven
    localparam int DEBOUNCE_CYCLES = 20;   // clocks a row level must hold
    localparam int ENTRY_DIGITS    = 4;    // digits accepted per operand

    // counter widths that follow from the constants above
    localparam int SCAN_CNT_W  = $clog2(SCAN_CYCLES);
    localparam int DEB_CNT_W   = $clog2(DEBOUNCE_CYCLES);
    localparam int DIGIT_CNT_W = $clog2(ENTRY_DIGITS + 1);

    // operator code sent from scanner to controller
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,  // sign toggle, only touches the entry
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    // scanner FSM, also exported on input_state
    typedef enum logic [2:0] {
        IDLE                = 3'd0,  // one cycle before scanning resumes
        SCAN_COL            = 3'd1,
        WAIT_STABLE         = 3'd2,  // press debounce
        CONFIRM             = 3'd3,  // key presented, waiting for key_read
        WAIT_RELEASE        = 3'd4,
        WAIT_RELEASE_STABLE = 3'd5   // release debounce
    } scan_state_t;

    // controller sequencing
    typedef enum logic [1:0] {
        READY = 2'd0,
        ACK   = 2'd1,
        DONE  = 2'd2
    } calc_state_t;

endpackage

// ==== keypad_scanner.sv ====
`timescale 1ns/1ps

module keypad_scanner import calc_pkg::*; (
    input  logic        clk,
    input  logic        nRST,
    input  logic [3:0]  row_in,          // pulled up, low when a key in the driven column is down
    input  logic        key_read,        // ack pulse from the controller
    output logic [3:0]  col_out,         // one column driven low at a time
    output logic        read_input,      // one pulse per accepted digit
    output logic [3:0]  keypad_input,    // digit value 0..9
    output op_t         operator_input,  // held while in CONFIRM
    output logic        equal_input,     // held while in CONFIRM
    output logic        key_pressed,
    output scan_state_t input_state
);

    scan_state_t state, next_state;

    logic [1:0]            col_index;   // column currently driven low
    logic [SCAN_CNT_W-1:0] scan_cnt;
    logic [DEB_CNT_W-1:0]  deb_cnt;
    logic                  deb_done;
    logic [3:0]            row_meta, row_sync;

    // key position and its decode
    logic [1:0] key_row;
    logic [3:0] key_pos;                 // 4*row + col
    logic [3:0] dec_digit;
    op_t        dec_op;
    logic       dec_equal;
    logic       dec_is_digit;
    logic       dec_pound;

    // two flop row synchronizer, idles high like the pull-ups
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_meta <= 4'b1111;
            row_sync <= 4'b1111;
        end else begin
            row_meta <= row_in;
            row_sync <= row_meta;
        end
    end

    assign key_pressed = ~&row_sync;     // any row pulled low
    assign input_state = state;
    assign deb_done    = (deb_cnt == DEB_CNT_W'(DEBOUNCE_CYCLES - 1));

    always_comb begin
        col_out            = 4'b1111;
        col_out[col_index] = 1'b0;
    end

    // lowest low row wins if several are down
    always_comb begin
        if (!row_sync[0])
            key_row = 2'd0;
        else if (!row_sync[1])
            key_row = 2'd1;
        else if (!row_sync[2])
            key_row = 2'd2;
        else
            key_row = 2'd3;
    end

    assign key_pos = {key_row, col_index};

    // column 3 holds the operators, row 3 has equals, 0 and pound
    assign dec_is_digit = (key_pos[1:0] != 2'd3) &&
                          ((key_pos[3:2] != 2'd3) || (key_pos[1:0] == 2'd1));
    assign dec_pound    = (key_pos == 4'hE);

    always_comb begin
        dec_digit = 4'd0;
        dec_op    = OP_NONE;
        dec_equal = 1'b0;
        case (key_pos)
            4'h0: dec_digit = 4'd1;
            4'h1: dec_digit = 4'd2;
            4'h2: dec_digit = 4'd3;
            4'h3: dec_op    = OP_ADD;
            4'h4: dec_digit = 4'd4;
            4'h5: dec_digit = 4'd5;
            4'h6: dec_digit = 4'd6;
            4'h7: dec_op    = OP_SUB;
            4'h8: dec_digit = 4'd7;
            4'h9: dec_digit = 4'd8;
            4'hA: dec_digit = 4'd9;
            4'hB: dec_op    = OP_MUL;
            4'hC: dec_equal = 1'b1;
            4'hD: dec_digit = 4'd0;
            4'hF: dec_op    = OP_NEG;
            default: ;                   // pound, decodes to nothing
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     next_state = SCAN_COL;
            SCAN_COL: next_state = key_pressed ? WAIT_STABLE : SCAN_COL;
            WAIT_STABLE: begin
                if (!key_pressed)
                    next_state = SCAN_COL;   // bounce or stale rows after a column change
                else if (deb_done)
                    next_state = dec_pound ? WAIT_RELEASE : CONFIRM;
            end
            CONFIRM:      next_state = key_read ? WAIT_RELEASE : CONFIRM;
            WAIT_RELEASE: next_state = key_pressed ? WAIT_RELEASE : WAIT_RELEASE_STABLE;
            WAIT_RELEASE_STABLE: begin
                if (key_pressed)
                    next_state = WAIT_RELEASE;  // release bounced, start over
                else if (deb_done)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= IDLE;
            col_index      <= 2'd0;
            scan_cnt       <= '0;
            deb_cnt        <= '0;
            read_input     <= 1'b0;
            keypad_input   <= 4'd0;
            operator_input <= OP_NONE;
            equal_input    <= 1'b0;
        end else begin
            state      <= next_state;
            read_input <= 1'b0;          // only high on the accept cycle

            // column only moves while scanning, so a held key freezes it
            if (state == SCAN_COL && next_state == SCAN_COL) begin
                if (scan_cnt == SCAN_CNT_W'(SCAN_CYCLES - 1)) begin
                    scan_cnt  <= '0;
                    col_index <= col_index + 2'd1;
                end else begin
                    scan_cnt <= scan_cnt + 1'b1;
                end
            end

            // shared by press and release debounce, restarts on any state change
            if (next_state != state)
                deb_cnt <= '0;
            else if (state == WAIT_STABLE || state == WAIT_RELEASE_STABLE)
                deb_cnt <= deb_cnt + 1'b1;

            // press accepted: present the key
            if (state == WAIT_STABLE && key_pressed && deb_done) begin
                keypad_input   <= dec_digit;
                operator_input <= dec_op;
                equal_input    <= dec_equal;
                read_input     <= dec_is_digit;
            end

            // levels drop once acked so the controller sees them once
            if (state == CONFIRM && key_read) begin
                operator_input <= OP_NONE;
                equal_input    <= 1'b0;
            end

            if (state == WAIT_RELEASE_STABLE && next_state == IDLE)
                keypad_input <= 4'd0;
        end
    end

endmodule

// ==== calc_controller.sv ====
`timescale 1ns/1ps

module calc_controller import calc_pkg::*; (
    input  logic               clk,
    input  logic               nRST,
    input  logic               read_input,      // digit strobe from scanner
    input  logic [3:0]         keypad_input,
    input  op_t                operator_input,  // level, cleared by scanner after ack
    input  logic               equal_input,     // level, cleared by scanner after ack
    output logic               key_read,
    output logic signed [31:0] entry,
    output logic signed [31:0] result,
    output logic               result_valid
);

    calc_state_t state;

    logic signed [31:0]     acc;        // left operand
    op_t                    pend_op;    // operator waiting for equals
    logic                   neg;        // entry sign, kept apart so -0 remembers it
    logic [DIGIT_CNT_W-1:0] digit_cnt;

    logic signed [31:0] digit_val;
    logic signed [31:0] entry_x10;
    logic signed [31:0] calc_val;
    logic               digit_room;

    assign key_read     = (state == ACK);
    assign result_valid = (state == DONE);

    assign digit_val  = {28'd0, keypad_input};
    assign entry_x10  = entry * 32'sd10;
    assign digit_room = (digit_cnt < DIGIT_CNT_W'(ENTRY_DIGITS));

    // accumulator op entry, wraps at 32 bits
    always_comb begin
        case (pend_op)
            OP_ADD:  calc_val = acc + entry;
            OP_SUB:  calc_val = acc - entry;
            OP_MUL:  calc_val = acc * entry;
            default: calc_val = entry;   // equals without operator
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= READY;
            entry     <= '0;
            result    <= '0;
            acc       <= '0;
            pend_op   <= OP_NONE;
            neg       <= 1'b0;
            digit_cnt <= '0;
        end else begin
            case (state)
                READY: begin
                    // act on the key here, ACK only answers the scanner
                    if (read_input) begin
                        state <= ACK;
                        if (digit_room) begin
                            // new digit follows the sign already on the entry
                            entry     <= neg ? (entry_x10 - digit_val) : (entry_x10 + digit_val);
                            digit_cnt <= digit_cnt + 1'b1;
                        end
                    end else if (equal_input) begin
                        state     <= ACK;
                        result    <= calc_val;
                        entry     <= '0;
                        acc       <= '0;
                        pend_op   <= OP_NONE;
                        neg       <= 1'b0;
                        digit_cnt <= '0;
                    end else if (operator_input == OP_NEG) begin
                        state <= ACK;
                        entry <= -entry;
                        neg   <= ~neg;
                    end else if (operator_input != OP_NONE) begin
                        state     <= ACK;
                        acc       <= entry;  // later operator replaces an earlier one
                        pend_op   <= operator_input;
                        entry     <= '0;
                        neg       <= 1'b0;
                        digit_cnt <= '0;
                    end
                end
                // equal_input is still held during the ack cycle
                ACK:     state <= equal_input ? DONE : READY;
                DONE:    state <= READY;     // result_valid high here
                default: state <= READY;
            endcase
        end
    end

endmodule

// ==== calc_top.sv ====
`timescale 1ns/1ps

module calc_top import calc_pkg::*; (
    input  logic               clk,
    input  logic               nRST,
    input  logic [3:0]         row_in,
    output logic [3:0]         col_out,
    output logic signed [31:0] entry,
    output logic signed [31:0] result,
    output logic               result_valid,
    output logic               key_pressed,
    output scan_state_t        input_state
);

    // scanner to controller
    logic       read_input;
    logic [3:0] keypad_input;
    op_t        operator_input;
    logic       equal_input;
    logic       key_read;           // back to scanner

    keypad_scanner scanner_i (
        .clk            (clk),
        .nRST           (nRST),
        .row_in         (row_in),
        .key_read       (key_read),
        .col_out        (col_out),
        .read_input     (read_input),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_pressed    (key_pressed),
        .input_state    (input_state)
    );

    calc_controller controller_i (
        .clk            (clk),
        .nRST           (nRST),
        .read_input     (read_input),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_read       (key_read),
        .entry          (entry),
        .result         (result),
        .result_valid   (result_valid)
    );

endmodule

// ==== calc_checker.sv ====
`timescale 1ns/1ps

module calc_checker import calc_pkg::*; (
    input logic        clk,
    input logic        nRST,
    input logic        read_input,
    input logic        key_read,
    input scan_state_t input_state,
    input logic [3:0]  col_out
);

    int fail_count = 0;  // failed assertions, read at end of run

    // digit strobe lasts one cycle only
    read_pulse_a: assert property (@(posedge clk) disable iff (!nRST)
        read_input |=> !read_input)
        else begin
            fail_count++;
            $error("read_input held high for more than one cycle");
        end

    // controller may only ack a key the scanner is presenting
    ack_in_confirm_a: assert property (@(posedge clk) disable iff (!nRST)
        key_read |-> input_state == CONFIRM)
        else begin
            fail_count++;
            $error("key_read seen while scanner not in CONFIRM");
        end

    // column frozen outside SCAN_COL so a pending key blocks new scans
    col_hold_a: assert property (@(posedge clk) disable iff (!nRST)
        input_state != SCAN_COL |=> $stable(col_out))
        else begin
            fail_count++;
            $error("col_out moved while the scanner was not scanning");
        end

endmodule

// ==== calc_monitor.sv ====
`timescale 1ns/1ps

module calc_monitor import calc_pkg::*; (
    input  logic               clk,
    input  logic               nRST,
    input  logic [3:0]         col_out,
    input  logic signed [31:0] entry,
    input  logic signed [31:0] result,
    input  logic               result_valid,
    input  logic               key_pressed,
    input  scan_state_t        input_state,
    input  logic               check_strobe,     // compare request after a key release
    input  logic               result_expected,  // equals key in flight
    input  logic signed [31:0] exp_entry,
    input  logic signed [31:0] exp_result,
    output int                 errors
);

    logic result_seen;  // result_valid arrived for the current equals

    initial begin
        errors      = 0;
        result_seen = 1'b0;
    end

    always @(posedge clk) begin
        if (nRST) begin
            if (result_valid) begin
                if (!result_expected || result_seen) begin
                    errors++;
                    $display("unexpected result: result_valid pulsed at %0t ns with no equals pending",
                             $time);
                end else begin
                    result_seen = 1'b1;
                    if (result !== exp_result) begin
                        errors++;
                        $display("ERR %0t ns: result %0d, expected %0d", $time, result, exp_result);
                    end
                end
            end
            if (check_strobe) begin
                if (entry !== exp_entry) begin
                    errors++;
                    $display("ERR %0t ns: entry %0d, expected %0d", $time, entry, exp_entry);
                end
                if (result !== exp_result) begin  // result holds until the next equals
                    errors++;
                    $display("ERR %0t ns: held result %0d, expected %0d", $time, result, exp_result);
                end
                if (result_valid !== 1'b0) begin
                    errors++;
                    $display("ERR %0t ns: result_valid high while idle", $time);
                end
                if ($countones(~col_out) != 1) begin
                    errors++;
                    $display("ERR %0t ns: col_out %b, expected one column low", $time, col_out);
                end
                if (key_pressed !== 1'b0) begin  // rows released long ago
                    errors++;
                    $display("ERR %0t ns: key_pressed high with no key down", $time);
                end
                // scanner back to scanning, nothing left waiting for an ack
                if (!(input_state === IDLE || input_state === SCAN_COL)) begin
                    errors++;
                    $display("ERR %0t ns: scanner state %0d, expected idle or scanning",
                             $time, input_state);
                end
                if (result_expected && !result_seen) begin
                    errors++;
                    $display("missing result: equals key at %0t ns never produced result_valid",
                             $time);
                end
                result_seen = 1'b0;
            end
        end
    end

endmodule

// ==== calc_tb.sv ====
`timescale 1ns/1ps

module calc_tb import calc_pkg::*; ();

    localparam int HOLD_CYCLES = 200;              // key held down
    localparam int GAP_CYCLES  = 200;              // released before next key
    localparam int KEY_BUDGET  = 14 + 32 + 16 + 6 + 6;  // worst case keys, tests 2 to 6
    localparam int POS_ADD     = 3;                // key positions, 4*row + col
    localparam int POS_SUB     = 7;
    localparam int POS_MUL     = 11;
    localparam int POS_EQ      = 12;
    localparam int POS_POUND   = 14;
    localparam int POS_NEG     = 15;

    int digit_pos [10] = '{13, 0, 1, 2, 4, 5, 6, 8, 9, 10};  // digit value to position
    int op_pos [3]     = '{POS_ADD, POS_SUB, POS_MUL};

    logic               clk;
    logic               nRST;
    logic [3:0]         row_in;
    logic [3:0]         col_out;
    logic signed [31:0] entry;
    logic signed [31:0] result;
    logic               result_valid;
    logic               key_pressed;
    scan_state_t        input_state;

    logic               key_down;          // keypad model
    logic [1:0]         key_row;
    logic [1:0]         key_col;
    logic               check_strobe;
    logic               result_expected;
    logic signed [31:0] exp_entry;         // reference calculator
    logic signed [31:0] exp_result;
    logic signed [31:0] acc;
    int                 pend_pos;          // latched operator key, -1 for none
    logic               neg;
    int                 digit_cnt;
    int                 seed = 32'h4ae3e42d;
    int                 errors;
    int                 err_mark = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;

    calc_top dut_i (
        .clk(clk), .nRST(nRST), .row_in(row_in), .col_out(col_out), .entry(entry),
        .result(result), .result_valid(result_valid), .key_pressed(key_pressed),
        .input_state(input_state)
    );

    calc_monitor mon_i (
        .clk(clk), .nRST(nRST), .col_out(col_out), .entry(entry), .result(result),
        .result_valid(result_valid), .key_pressed(key_pressed), .input_state(input_state),
        .check_strobe(check_strobe), .result_expected(result_expected),
        .exp_entry(exp_entry), .exp_result(exp_result), .errors(errors)
    );

    bind keypad_scanner calc_checker checker_i (
        .clk(clk), .nRST(nRST), .read_input(read_input), .key_read(key_read),
        .input_state(input_state), .col_out(col_out)
    );

    always #5 clk = ~clk;

    // held key shorts its row to its column while that column is low
    always_comb begin
        row_in = 4'b1111;
        if (key_down && !col_out[key_col])
            row_in[key_row] = 1'b0;
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    function automatic int total_errors();
        return errors + dut_i.scanner_i.checker_i.fail_count;
    endfunction

    // reference calculator, stepped as each key goes down
    task automatic model_key(input int pos);
        int digit;
        digit = -1;
        for (int d = 0; d < 10; d++)
            if (digit_pos[d] == pos)
                digit = d;
        if (digit >= 0) begin
            if (digit_cnt < ENTRY_DIGITS) begin   // extra digits dropped
                exp_entry = neg ? exp_entry * 10 - digit : exp_entry * 10 + digit;
                digit_cnt++;
            end
        end else if (pos == POS_NEG) begin
            exp_entry = -exp_entry;
            neg       = ~neg;
        end else if (pos == POS_EQ) begin
            case (pend_pos)
                POS_ADD: exp_result = acc + exp_entry;
                POS_SUB: exp_result = acc - exp_entry;
                POS_MUL: exp_result = acc * exp_entry;
                default: exp_result = exp_entry;
            endcase
            result_expected = 1'b1;
            acc       = 0;
            pend_pos  = -1;
            exp_entry = 0;
            neg       = 1'b0;
            digit_cnt = 0;
        end else if (pos != POS_POUND) begin      // add, subtract, multiply
            acc       = exp_entry;
            pend_pos  = pos;
            exp_entry = 0;
            neg       = 1'b0;
            digit_cnt = 0;
        end
    endtask

    task automatic check_now();
        check_strobe = 1'b1;
        @(negedge clk);
        check_strobe    = 1'b0;
        result_expected = 1'b0;
    endtask

    // called on a falling edge, returns on one
    task automatic press(input int pos);
        model_key(pos);
        key_row  = 2'(pos / 4);
        key_col  = 2'(pos % 4);
        key_down = 1'b1;
        repeat (HOLD_CYCLES) @(negedge clk);
        key_down = 1'b0;
        repeat (GAP_CYCLES) @(negedge clk);
        check_now();
    endtask

    task automatic press_operand();
        int n;
        n = 1 + rand_below(3);
        repeat (n) press(digit_pos[rand_below(10)]);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() != err_mark) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, total_errors() - err_mark);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        err_mark = total_errors();
    endtask

    initial begin
        clk             = 1'b0;
        nRST            = 1'b0;
        key_down        = 1'b0;
        key_row         = 2'd0;
        key_col         = 2'd0;
        check_strobe    = 1'b0;
        result_expected = 1'b0;
        exp_entry       = 0;
        exp_result      = 0;
        acc             = 0;
        pend_pos        = -1;
        neg             = 1'b0;
        digit_cnt       = 0;
        repeat (2) @(negedge clk);
        nRST = 1'b1;

        check_now();
        end_test("reset values");

        for (int r = 0; r < 2; r++) begin     // six digits, only four taken
            repeat (6) press(digit_pos[rand_below(10)]);
            press(POS_EQ);
        end
        end_test("digit entry");

        for (int r = 0; r < 4; r++) begin
            press_operand();
            press(op_pos[rand_below(3)]);
            press_operand();
            press(POS_EQ);
        end
        end_test("binary operations");

        for (int r = 0; r < 2; r++) begin
            press(POS_NEG);                    // toggle on an empty entry
            repeat (2) press(digit_pos[rand_below(10)]);
            press(op_pos[rand_below(3)]);
            press(digit_pos[rand_below(10)]);
            press(POS_NEG);                    // toggle between digits
            press(digit_pos[rand_below(10)]);
            press(POS_EQ);
        end
        end_test("sign toggle");

        press(digit_pos[rand_below(10)]);
        press(POS_POUND);
        press(digit_pos[rand_below(10)]);
        press(POS_POUND);
        press(digit_pos[rand_below(10)]);
        press(POS_EQ);
        end_test("pound ignored");

        repeat (2) press(digit_pos[rand_below(10)]);
        press(POS_EQ);
        press(POS_ADD);                        // accumulator must start from zero
        press(digit_pos[rand_below(10)]);
        press(POS_EQ);
        end_test("equals without operator");

        $display("tests run %0d, failed %0d, compare errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut_i.scanner_i.checker_i.fail_count);
        if (tests_failed == 0 && total_errors() == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // twice the worst case time for every key
    initial begin
        repeat (KEY_BUDGET * (HOLD_CYCLES + GAP_CYCLES) * 2) @(posedge clk);
        $display("timeout: key sequences did not finish in time, run stopped");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
calc_pkg.sv
keypad_scanner.sv
calc_controller.sv
calc_top.sv
calc_checker.sv
calc_monitor.sv
calc_tb.sv
